// ==== flist.f ====
+incdir+verilog
+incdir+test
verilog/sched_types_pkg.sv
verilog/sched_ctl_pkg.sv
verilog/warp_table.sv
verilog/barrier_unit.sv
verilog/warp_picker.sv
verilog/pending_tracker.sv
verilog/warp_sched_top.sv
test/tb_warp_sched.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the warp scheduler testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
    -f flist.f --top-module tb_warp_sched -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_warp_sched 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qxF '>>> PASS' <<< "$sim_output"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== test/sched_trace.txt ====
# cv op wid tm wm pc bid bsz | bv bwid tk dest | uv uwid | iv iwid cm | ev ewid etm epc busy
# hex, one cycle per line: inputs of the cycle, then sched and busy expected in that cycle
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  0 0 0 00000000 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  1 0 1 80000000 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  0 0 0 00000000 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  1 0  0 0 0  0 0 0 00000000 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  0 0 0 00000000 1
1 1 0 0 e 00001000 0 0  0 0 0 00000000  0 0  0 0 0  1 0 1 80000004 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  0 0 0 00000000 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  1 0 1 80000008 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  1 1 1 00001000 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  1 2 1 00001000 1
1 1 1 0 4 0000f000 0 0  0 0 0 00000000  0 0  0 0 0  1 3 1 00001000 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  0 0 0 00000000 1
0 0 0 0 0 00000000 0 0  1 0 1 80000100  1 2  0 0 0  1 1 1 00001004 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  0 0 0 00000000 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  1 0 1 80000100 1
0 0 0 0 0 00000000 0 0  1 3 0 deadbee0  0 0  0 0 0  1 2 1 00001004 1
1 0 1 b 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  0 0 0 00000000 1
1 0 2 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  1 3 1 00001004 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  1 2  0 0 0  1 1 b 00001008 1
1 2 0 0 0 00000000 1 2  0 0 0 00000000  0 0  0 0 0  0 0 0 00000000 1
1 2 3 0 0 00000000 1 2  0 0 0 00000000  0 0  0 0 0  0 0 0 00000000 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  1 1  0 0 0  0 0 0 00000000 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  0 0 0 00000000 1
1 2 1 0 0 00000000 1 2  0 0 0 00000000  0 0  0 0 0  1 1 b 0000100c 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  0 0 0 00000000 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  1 0 1 80000104 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  1 1 b 00001010 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  1 0 0  1 3 1 00001008 1
1 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  1 3 0  0 0 0 00000000 1
1 0 1 0 0 00000000 0 0  0 0 0 00000000  0 0  1 0 1  0 0 0 00000000 1
1 0 3 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 8  0 0 0 00000000 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 1  0 0 0 00000000 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  0 0 0 00000000 1
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  0 0 0 00000000 0
0 0 0 0 0 00000000 0 0  0 0 0 00000000  0 0  0 0 0  0 0 0 00000000 0

// ==== test/tb_checks.svh ====
// typed compare tasks for the warp scheduler testbench, included inside its top module

// valid and busy flags
task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("Fail at time %0t: %s expected %b, got %b", $time, name, expected, actual);
        report_failure();
    end
endtask

task automatic check_wid(input string name, input wid_t expected, input wid_t actual);
    if (actual !== expected) begin
        $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        report_failure();
    end
endtask

task automatic check_tmask(input string name, input tmask_t expected, input tmask_t actual);
    if (actual !== expected) begin
        $display("Fail at time %0t: %s expected %b, got %b", $time, name, expected, actual);
        report_failure();
    end
endtask

task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
    if (actual !== expected) begin
        $display("Fail at time %0t: %s expected %h, got %h", $time, name, expected, actual);
        report_failure();
    end
endtask

// wid, mask and pc only mean something on a strobe
task automatic check_step(input trace_step_t step);
    check_bit("sched.valid", step.exp_sched.valid, sched.valid);
    if (step.exp_sched.valid) begin
        check_wid("sched.wid", step.exp_sched.wid, sched.wid);
        check_tmask("sched.tmask", step.exp_sched.tmask, sched.tmask);
        check_pc("sched.pc", step.exp_sched.pc, sched.pc);
    end
    check_bit("busy", step.exp_busy, busy);
endtask

// ==== test/tb_warp_sched.sv ====
// testbench for the warp scheduler, replays the per-cycle trace and checks sched and busy
`timescale 1ns/1ns

module tb_warp_sched import sched_types_pkg::*, sched_ctl_pkg::*; ();

    localparam int    CLK_PERIOD     = 4;
    localparam int    RESET_CYCLES   = 3;
    localparam int    TIMEOUT_MARGIN = 20;
    localparam int    TRACE_FIELDS   = 22;
    localparam string TRACE_PATH     = "test/sched_trace.txt";

    // one trace line of inputs followed by expected outputs
    typedef struct packed {
        warp_ctl_t  warp_ctl;
        branch_t    branch;
        logic       unlock_valid;
        wid_t       unlock_wid;
        logic       issue_valid;
        wid_t       issue_wid;
        warp_mask_t commit_wmask;
        sched_out_t exp_sched;
        logic       exp_busy;
    } trace_step_t;

    logic        clk;
    logic        reset;
    warp_ctl_t   warp_ctl;
    branch_t     branch;
    logic        unlock_valid;
    wid_t        unlock_wid;
    logic        issue_valid;
    wid_t        issue_wid;
    warp_mask_t  commit_wmask;
    sched_out_t  sched;
    logic        busy;

    trace_step_t steps[$];
    int          cycle_count = 0;
    int          cycle_limit;

    warp_sched_top dut (
        .clk          (clk),
        .reset        (reset),
        .warp_ctl     (warp_ctl),
        .branch       (branch),
        .unlock_valid (unlock_valid),
        .unlock_wid   (unlock_wid),
        .issue_valid  (issue_valid),
        .issue_wid    (issue_wid),
        .commit_wmask (commit_wmask),
        .sched        (sched),
        .busy         (busy)
    );

    task automatic report_failure();
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "tb_checks.svh"

    task automatic load_trace();
        int          fd;
        int          n;
        int          line_no;
        string       line;
        logic [31:0] f [TRACE_FIELDS];
        trace_step_t step;
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) begin
            $display("cannot open trace file %s", TRACE_PATH);
            report_failure();
        end
        line_no = 0;
        while ($fgets(line, fd) > 0) begin
            line_no++;
            // skip comments and blank lines
            if (line.len() <= 1 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21]);
            if (n != TRACE_FIELDS) begin
                $display("trace line %0d holds %0d fields instead of %0d", line_no, n, TRACE_FIELDS);
                report_failure();
            end
            step                      = '0;
            step.warp_ctl.valid       = f[0][0];
            step.warp_ctl.op          = warp_op_e'(f[1][1:0]);
            step.warp_ctl.wid         = wid_t'(f[2]);
            step.warp_ctl.tmask       = tmask_t'(f[3]);
            step.warp_ctl.wmask       = warp_mask_t'(f[4]);
            step.warp_ctl.pc          = pc_t'(f[5]);
            step.warp_ctl.bar_id      = bar_id_t'(f[6]);
            step.warp_ctl.bar_size_m1 = wid_t'(f[7]);
            step.branch.valid         = f[8][0];
            step.branch.wid           = wid_t'(f[9]);
            step.branch.taken         = f[10][0];
            step.branch.dest          = pc_t'(f[11]);
            step.unlock_valid         = f[12][0];
            step.unlock_wid           = wid_t'(f[13]);
            step.issue_valid          = f[14][0];
            step.issue_wid            = wid_t'(f[15]);
            step.commit_wmask         = warp_mask_t'(f[16]);
            step.exp_sched.valid      = f[17][0];
            step.exp_sched.wid        = wid_t'(f[18]);
            step.exp_sched.tmask      = tmask_t'(f[19]);
            step.exp_sched.pc         = pc_t'(f[20]);
            step.exp_busy             = f[21][0];
            steps.push_back(step);
        end
        $fclose(fd);
        if (steps.size() == 0) begin
            $display("trace file %s holds no cycles", TRACE_PATH);
            report_failure();
        end
    endtask

    task automatic drive_step(input trace_step_t step);
        warp_ctl     <= step.warp_ctl;
        branch       <= step.branch;
        unlock_valid <= step.unlock_valid;
        unlock_wid   <= step.unlock_wid;
        issue_valid  <= step.issue_valid;
        issue_wid    <= step.issue_wid;
        commit_wmask <= step.commit_wmask;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: trace replay still running after %0d cycles", cycle_count);
            report_failure();
        end
    end

    initial begin
        reset        = 1'b1;
        warp_ctl     = '0;
        branch       = '0;
        unlock_valid = 1'b0;
        unlock_wid   = '0;
        issue_valid  = 1'b0;
        issue_wid    = '0;
        commit_wmask = '0;
        load_trace();
        cycle_limit = RESET_CYCLES + steps.size() + TIMEOUT_MARGIN;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // trace line i is cycle i after reset release
        foreach (steps[i]) begin
            drive_step(steps[i]);
            @(negedge clk);
            check_step(steps[i]);
            @(posedge clk);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== verilog/barrier_unit.sv ====
// local barrier counters and arrival masks, producing the set of warps held at a barrier
`timescale 1ns/1ns
`include "sched_defs.svh"

module barrier_unit import sched_types_pkg::*, sched_ctl_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  warp_ctl_t  warp_ctl,
    output warp_mask_t bar_wait
);
    warp_mask_t [`NUM_BARRIERS-1:0] bar_masks;
    wid_t [`NUM_BARRIERS-1:0]       bar_cnts;
    logic                           bar_op;
    logic                           bar_last;

    assign bar_op   = warp_ctl.valid && (warp_ctl.op == op_bar);
    // caller completes the member count
    assign bar_last = (bar_cnts[warp_ctl.bar_id] == warp_ctl.bar_size_m1);

    always_ff @(posedge clk) begin
        if (reset) begin
            bar_masks <= '0;
            bar_cnts  <= '0;
            bar_wait  <= '0;
        end else if (bar_op) begin
            if (bar_last) begin
                // release everyone already waiting here
                bar_cnts[warp_ctl.bar_id]  <= '0;
                bar_masks[warp_ctl.bar_id] <= '0;
                bar_wait                   <= bar_wait & ~bar_masks[warp_ctl.bar_id];
            end else begin
                bar_cnts[warp_ctl.bar_id]               <= bar_cnts[warp_ctl.bar_id] + wid_t'(1);
                bar_masks[warp_ctl.bar_id][warp_ctl.wid] <= 1'b1;
                bar_wait[warp_ctl.wid]                   <= 1'b1;
            end
        end
    end

    // a waiting warp cannot issue another barrier
    no_rearrival: assert property (@(posedge clk) disable iff (reset)
        bar_op |-> !bar_wait[warp_ctl.wid])
    else $error("warp %0d arrived at a barrier while waiting", warp_ctl.wid);

endmodule

// ==== verilog/pending_tracker.sv ====
// per-warp in-flight instruction counters and the registered scheduler busy flag
`timescale 1ns/1ns
`include "sched_defs.svh"

module pending_tracker import sched_types_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       issue_valid,
    input  wid_t       issue_wid,
    input  warp_mask_t commit_wmask,
    input  warp_mask_t active_warps,
    output logic       busy
);
    logic [`NUM_WARPS-1:0][`PENDING_BITS-1:0] pending_cnts;
    warp_mask_t                               warp_pending;

    for (genvar i = 0; i < `NUM_WARPS; i++) begin : g_pending
        logic issue_hit;

        assign issue_hit = issue_valid && (issue_wid == wid_t'(i));

        // issue and commit together leave the count unchanged
        always_ff @(posedge clk) begin
            if (reset) begin
                pending_cnts[i] <= '0;
            end else if (issue_hit && !commit_wmask[i]) begin
                pending_cnts[i] <= pending_cnts[i] + 1'b1;
            end else if (!issue_hit && commit_wmask[i]) begin
                pending_cnts[i] <= pending_cnts[i] - 1'b1;
            end
        end

        assign warp_pending[i] = (pending_cnts[i] != '0);

        no_underflow: assert property (@(posedge clk) disable iff (reset)
            commit_wmask[i] |-> (pending_cnts[i] != '0))
        else $error("commit on warp %0d with nothing in flight", i);

        no_overflow: assert property (@(posedge clk) disable iff (reset)
            issue_hit |-> (pending_cnts[i] != '1))
        else $error("issue on warp %0d with a full counter", i);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b1;
        end else begin
            busy <= (active_warps != '0) || (warp_pending != '0);
        end
    end

endmodule

// ==== verilog/sched_ctl_pkg.sv ====
// control, branch and schedule bundles that travel between the scheduler and the pipeline
package sched_ctl_pkg;
    import sched_types_pkg::*;

    // warp control operation kinds
    typedef enum logic [1:0] {
        op_tmc    = 2'd0,
        op_wspawn = 2'd1,
        op_bar    = 2'd2
    } warp_op_e;

    // warp control request from the execute stage
    typedef struct packed {
        logic       valid;
        warp_op_e   op;
        wid_t       wid;
        // new thread mask for tmc
        tmask_t     tmask;
        // warps to spawn and their start pc
        warp_mask_t wmask;
        pc_t        pc;
        // barrier number and member count minus one
        bar_id_t    bar_id;
        wid_t       bar_size_m1;
    } warp_ctl_t;

    // resolved branch
    typedef struct packed {
        logic valid;
        wid_t wid;
        logic taken;
        pc_t  dest;
    } branch_t;

    // strobe towards fetch
    typedef struct packed {
        logic   valid;
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
    } sched_out_t;

endpackage

// ==== verilog/sched_defs.svh ====
// sizes and reset constants for the warp scheduler, included by its packages and RTL
`ifndef SCHED_DEFS_SVH
`define SCHED_DEFS_SVH

// warp and thread geometry
`define NUM_WARPS 4
`define NUM_THREADS 4

// program counter width
`define PC_BITS 32

// local barriers per core
`define NUM_BARRIERS 2

// width of each in-flight instruction counter
`define PENDING_BITS 4

// warp 0 boot address and the fetch stride
`define START_PC 32'h8000_0000
`define PC_STEP 4

`endif

// ==== verilog/sched_types_pkg.sv ====
// vector types for warp numbers, masks and PCs, imported by the scheduler packages and RTL
`include "sched_defs.svh"

package sched_types_pkg;

    // warp number
    typedef logic [$clog2(`NUM_WARPS)-1:0] wid_t;

    // one bit per warp
    typedef logic [`NUM_WARPS-1:0] warp_mask_t;

    // one bit per thread inside a warp
    typedef logic [`NUM_THREADS-1:0] tmask_t;

    // instruction address
    typedef logic [`PC_BITS-1:0] pc_t;

    // local barrier number
    typedef logic [$clog2(`NUM_BARRIERS)-1:0] bar_id_t;

endpackage

// ==== verilog/warp_picker.sv ====
// selects the lowest ready warp each cycle and registers its schedule strobe for fetch
`timescale 1ns/1ns
`include "sched_defs.svh"

module warp_picker import sched_types_pkg::*, sched_ctl_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  warp_mask_t              active_warps,
    input  warp_mask_t              locked_warps,
    input  warp_mask_t              bar_wait,
    input  tmask_t [`NUM_WARPS-1:0] warp_tmasks,
    input  pc_t [`NUM_WARPS-1:0]    warp_pcs,
    output logic                    pick_valid,
    output wid_t                    pick_wid,
    output sched_out_t              sched
);
    warp_mask_t ready_warps;

    assign ready_warps = active_warps & ~locked_warps & ~bar_wait;

    // lowest index wins, so scan downwards
    always_comb begin
        pick_valid = 1'b0;
        pick_wid   = '0;
        for (int i = `NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                pick_valid = 1'b1;
                pick_wid   = wid_t'(i);
            end
        end
    end

    // state captured at pick time
    always_ff @(posedge clk) begin
        if (reset) begin
            sched <= '0;
        end else begin
            sched.valid <= pick_valid;
            sched.wid   <= pick_wid;
            sched.tmask <= warp_tmasks[pick_wid];
            sched.pc    <= warp_pcs[pick_wid];
        end
    end

    // the fetch lock must hold a warp out for at least one cycle
    no_back_to_back: assert property (@(posedge clk) disable iff (reset)
        sched.valid |=> !(sched.valid && (sched.wid == $past(sched.wid))))
    else $error("warp %0d scheduled on consecutive cycles", sched.wid);

endmodule

// ==== verilog/warp_sched_top.sv ====
// warp scheduler top level connecting the warp table, barriers, picker and pending counters
`timescale 1ns/1ns
`include "sched_defs.svh"

module warp_sched_top import sched_types_pkg::*, sched_ctl_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  warp_ctl_t  warp_ctl,
    input  branch_t    branch,
    input  logic       unlock_valid,
    input  wid_t       unlock_wid,
    input  logic       issue_valid,
    input  wid_t       issue_wid,
    input  warp_mask_t commit_wmask,
    output sched_out_t sched,
    output logic       busy
);
    warp_mask_t              active_warps;
    warp_mask_t              locked_warps;
    warp_mask_t              bar_wait;
    tmask_t [`NUM_WARPS-1:0] warp_tmasks;
    pc_t [`NUM_WARPS-1:0]    warp_pcs;
    logic                    pick_valid;
    wid_t                    pick_wid;

    warp_table u_warp_table (
        .clk          (clk),
        .reset        (reset),
        .warp_ctl     (warp_ctl),
        .branch       (branch),
        .unlock_valid (unlock_valid),
        .unlock_wid   (unlock_wid),
        .pick_valid   (pick_valid),
        .pick_wid     (pick_wid),
        .active_warps (active_warps),
        .locked_warps (locked_warps),
        .warp_tmasks  (warp_tmasks),
        .warp_pcs     (warp_pcs)
    );

    barrier_unit u_barrier_unit (
        .clk      (clk),
        .reset    (reset),
        .warp_ctl (warp_ctl),
        .bar_wait (bar_wait)
    );

    warp_picker u_warp_picker (
        .clk          (clk),
        .reset        (reset),
        .active_warps (active_warps),
        .locked_warps (locked_warps),
        .bar_wait     (bar_wait),
        .warp_tmasks  (warp_tmasks),
        .warp_pcs     (warp_pcs),
        .pick_valid   (pick_valid),
        .pick_wid     (pick_wid),
        .sched        (sched)
    );

    pending_tracker u_pending_tracker (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_wid    (issue_wid),
        .commit_wmask (commit_wmask),
        .active_warps (active_warps),
        .busy         (busy)
    );

endmodule

// ==== verilog/warp_table.sv ====
// per-warp active, lock, thread mask and pc registers with their ordered update rules
`timescale 1ns/1ns
`include "sched_defs.svh"

module warp_table import sched_types_pkg::*, sched_ctl_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  warp_ctl_t               warp_ctl,
    input  branch_t                 branch,
    input  logic                    unlock_valid,
    input  wid_t                    unlock_wid,
    input  logic                    pick_valid,
    input  wid_t                    pick_wid,
    output warp_mask_t              active_warps,
    output warp_mask_t              locked_warps,
    output tmask_t [`NUM_WARPS-1:0] warp_tmasks,
    output pc_t [`NUM_WARPS-1:0]    warp_pcs
);
    localparam int CNT_BITS = $clog2(`NUM_WARPS + 1);

    warp_mask_t              active_n;
    warp_mask_t              locked_n;
    tmask_t [`NUM_WARPS-1:0] tmasks_n;
    pc_t [`NUM_WARPS-1:0]    pcs_n;
    logic [CNT_BITS-1:0]     active_cnt;
    logic                    single_active;
    logic                    is_tmc;
    logic                    is_wspawn;
    logic                    is_bar;

    assign is_tmc    = warp_ctl.valid && (warp_ctl.op == op_tmc);
    assign is_wspawn = warp_ctl.valid && (warp_ctl.op == op_wspawn);
    assign is_bar    = warp_ctl.valid && (warp_ctl.op == op_bar);

    // population count of active warps
    always_comb begin
        active_cnt = '0;
        for (int i = 0; i < `NUM_WARPS; i++) begin
            active_cnt = active_cnt + CNT_BITS'(active_warps[i]);
        end
    end

    // later rules override earlier ones
    always_comb begin
        active_n = active_warps;
        locked_n = locked_warps;
        tmasks_n = warp_tmasks;
        pcs_n    = warp_pcs;

        if (unlock_valid) begin
            locked_n[unlock_wid] = 1'b0;
        end

        // spawn only from a single running warp
        if (is_wspawn) begin
            if (single_active) begin
                active_n = active_n | warp_ctl.wmask;
                for (int i = 0; i < `NUM_WARPS; i++) begin
                    if (warp_ctl.wmask[i]) begin
                        tmasks_n[i] = tmask_t'(1);
                        pcs_n[i]    = warp_ctl.pc;
                    end
                end
            end
            locked_n[warp_ctl.wid] = 1'b0;
        end

        // empty mask retires the warp
        if (is_tmc) begin
            tmasks_n[warp_ctl.wid] = warp_ctl.tmask;
            active_n[warp_ctl.wid] = (warp_ctl.tmask != '0);
            locked_n[warp_ctl.wid] = 1'b0;
        end

        // barrier_unit holds the caller out if it must wait
        if (is_bar) begin
            locked_n[warp_ctl.wid] = 1'b0;
        end

        if (branch.valid) begin
            if (branch.taken) begin
                pcs_n[branch.wid] = branch.dest;
            end
            locked_n[branch.wid] = 1'b0;
        end

        // lock until decode releases it
        if (pick_valid) begin
            locked_n[pick_wid] = 1'b1;
            pcs_n[pick_wid]    = warp_pcs[pick_wid] + pc_t'(`PC_STEP);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // only warp 0 runs out of reset
            active_warps  <= warp_mask_t'(1);
            locked_warps  <= '0;
            single_active <= 1'b1;
            for (int i = 0; i < `NUM_WARPS; i++) begin
                warp_tmasks[i] <= (i == 0) ? tmask_t'(1) : tmask_t'(0);
                warp_pcs[i]    <= (i == 0) ? pc_t'(`START_PC) : pc_t'(0);
            end
        end else begin
            active_warps  <= active_n;
            locked_warps  <= locked_n;
            single_active <= (active_cnt == CNT_BITS'(1));
            warp_tmasks   <= tmasks_n;
            warp_pcs      <= pcs_n;
        end
    end

    // tmc comes from an instruction of a running warp
    tmc_on_active: assert property (@(posedge clk) disable iff (reset)
        is_tmc |-> active_warps[warp_ctl.wid])
    else $error("tmc targets inactive warp %0d", warp_ctl.wid);

endmodule
